// File: bank_pkg.sv
// Shared widths, vector types, RAM structs and FSM encodings; imported by every ledger module
package bank_pkg;

	// 2**ACCT_W accounts in the balance RAM
	localparam int ACCT_W    = 4;
	localparam int KEY_W     = 8;
	localparam int AMOUNT_W  = 8;
	localparam int BALANCE_W = 16;

	typedef logic [KEY_W-1:0]     key_t;
	typedef logic [AMOUNT_W-1:0]  amount_t;
	typedef logic [BALANCE_W-1:0] balance_t;
	typedef logic [ACCT_W-1:0]    acct_t;

	// One RAM access as seen by the arbiter
	typedef struct packed {
		logic     we;
		acct_t    addr;
		balance_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic     approved;
		acct_t    acct;
		balance_t balance;
	} result_t;

	typedef enum logic [2:0] {
		idle,
		load_key,
		load_amount,
		ready,
		busy
	} main_state_t;

	typedef enum logic [2:0] {
		step_idle,
		step_hash,
		step_read,
		step_check,
		step_store
	} step_t;

endpackage

// File: ram_unit.sv
// Single-port balance RAM with synchronous write and registered read, driven by the arbiter
`timescale 1ns/10ps

module ram_unit #(
	parameter int ACCT_W = bank_pkg::ACCT_W
) (
	input  logic               clock,
	input  bank_pkg::mem_req_t mem,
	input  logic               en,
	output bank_pkg::balance_t rdata
);
	import bank_pkg::*;

	balance_t words [2**ACCT_W];

	// Read returns the old word on a write cycle
	always_ff @(posedge clock)
	begin
		if (en)
		begin
			if (mem.we)
				words[mem.addr[ACCT_W-1:0]] <= mem.wdata;
			rdata <= words[mem.addr[ACCT_W-1:0]];
		end
	end

endmodule

// File: ram_arbiter.sv
// Fixed-priority RAM arbiter; reader first, writer second, host last, with read data routed back
`timescale 1ns/10ps

module ram_arbiter #(
	parameter int ACCT_W = bank_pkg::ACCT_W
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               rd_req,
	input  logic               wr_req,
	input  logic               host_req,
	input  bank_pkg::mem_req_t rd_mem,
	input  bank_pkg::mem_req_t wr_mem,
	input  bank_pkg::mem_req_t host_mem,
	output logic               rd_gnt,
	output logic               wr_gnt,
	output logic               host_gnt,
	output logic               rd_rvalid,
	output logic               host_rvalid,
	output bank_pkg::balance_t rdata
);
	import bank_pkg::*;

	mem_req_t ram_mem;
	logic     ram_en;

	assign rd_gnt = rd_req;
	assign wr_gnt = wr_req && !rd_req;
	assign host_gnt = host_req && !rd_req && !wr_req;
	assign ram_en = rd_req || wr_req || host_req;

	always_comb
	begin
		if (rd_gnt)
			ram_mem = rd_mem;
		else if (wr_gnt)
			ram_mem = wr_mem;
		else
			ram_mem = host_mem;
	end

	// RAM output is registered, so the matching rvalid follows one cycle later
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			rd_rvalid <= 1'b0;
			host_rvalid <= 1'b0;
		end
		else
		begin
			rd_rvalid <= rd_gnt && !rd_mem.we;
			host_rvalid <= host_gnt && !host_mem.we;
		end
	end

	ram_unit #(
		.ACCT_W (ACCT_W)
	) u_ram_unit (
		.clock (clock),
		.mem   (ram_mem),
		.en    (ram_en),
		.rdata (rdata)
	);

	// A waiting host request keeps its payload until granted
	assert property (@(posedge clock) disable iff (!rst_n)
		host_req && !host_gnt |=> host_req && $stable(host_mem));

endmodule

// File: main_control.sv
// User-side controller; latches key and amount from the switches and launches one transaction
`timescale 1ns/10ps

module main_control (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              load,
	input  logic              start,
	input  bank_pkg::key_t    sw,
	input  logic              finished,
	output logic              start_transaction,
	output bank_pkg::key_t    key,
	output bank_pkg::amount_t amount
);
	import bank_pkg::*;

	main_state_t state;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			state <= idle;
			start_transaction <= 1'b0;
		end
		else
		begin
			start_transaction <= 1'b0;
			case (state)
				// A load seen in idle already counts as the key
				idle:
				begin
					if (load)
						state <= load_amount;
					else
						state <= load_key;
				end
				load_key:
				begin
					if (load)
						state <= load_amount;
				end
				load_amount:
				begin
					if (load)
						state <= ready;
				end
				ready:
				begin
					if (start)
					begin
						state <= busy;
						start_transaction <= 1'b1;
					end
				end
				// Loads and starts are dropped until the sequencer finishes
				busy:
				begin
					if (finished)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// Switch capture follows the load that the FSM accepts
	always_ff @(posedge clock)
	begin
		if (load && (state == idle || state == load_key))
			key <= sw;
		if (load && state == load_amount)
			amount <= amount_t'(sw);
	end

	// Sequencer only finishes a transaction that was launched from here
	assert property (@(posedge clock) disable iff (!rst_n)
		finished |-> state == busy);

endmodule

// File: transaction_control.sv
// Step sequencer; walks hash, read, check and store, then pulses finished to the user controller
`timescale 1ns/10ps

module transaction_control (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            start_transaction,
	input  logic            dp_done,
	input  logic            rd_done,
	input  logic            wr_done,
	output bank_pkg::step_t step,
	output logic            finished
);
	import bank_pkg::*;

	logic done_step;

	// Owner of the current step reports its completion
	always_comb
	begin
		case (step)
			step_hash:  done_step = dp_done;
			step_read:  done_step = rd_done;
			step_check: done_step = dp_done;
			step_store: done_step = wr_done;
			default:    done_step = 1'b0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			step <= step_idle;
			finished <= 1'b0;
		end
		else
		begin
			finished <= 1'b0;
			case (step)
				step_idle:
				begin
					if (start_transaction)
						step <= step_hash;
				end
				step_hash:
				begin
					if (done_step)
						step <= step_read;
				end
				step_read:
				begin
					if (done_step)
						step <= step_check;
				end
				step_check:
				begin
					if (done_step)
						step <= step_store;
				end
				step_store:
				begin
					if (done_step)
					begin
						step <= step_idle;
						finished <= 1'b1;
					end
				end
				default: step <= step_idle;
			endcase
		end
	end

	// No new launch may land on the finish cycle
	assert property (@(posedge clock) disable iff (!rst_n)
		finished |=> step == step_idle);

endmodule

// File: datapath.sv
// Ledger datapath; hashes the key to an account and decides approval and the new balance
`timescale 1ns/10ps

module datapath #(
	parameter int ACCT_W = bank_pkg::ACCT_W
) (
	input  logic               clock,
	input  logic               rst_n,
	input  bank_pkg::step_t    step,
	input  bank_pkg::key_t     key,
	input  bank_pkg::amount_t  amount,
	input  bank_pkg::balance_t balance_in,
	output bank_pkg::acct_t    acct,
	output bank_pkg::balance_t new_balance,
	output bank_pkg::result_t  result,
	output logic               done_step,
	output logic               done
);
	import bank_pkg::*;

	localparam int unsigned N_ACCT = 1 << ACCT_W;

	logic [3:0] nibble_x;
	logic       approved;
	balance_t   amount_ext;
	balance_t   next_balance;

	// Toy hash, XOR of the key nibbles folded into the account space
	assign nibble_x = key[7:4] ^ key[3:0];

	assign amount_ext = balance_t'(amount);
	assign approved = amount_ext <= balance_in;
	assign next_balance = approved ? balance_in - amount_ext : balance_in;

	// Writer stores whatever the check step decided
	assign new_balance = result.balance;

	always_ff @(posedge clock)
	begin
		if (step == step_hash && !done_step)
			acct <= acct_t'(nibble_x % N_ACCT);
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			done_step <= 1'b0;
			done <= 1'b0;
			result <= '0;
		end
		else
		begin
			// One-cycle work per step, pulse once then wait for the next step
			done_step <= (step == step_hash || step == step_check) && !done_step;
			done <= step == step_check && !done_step;
			if (step == step_check && !done_step)
				result <= '{approved: approved, acct: acct, balance: next_balance};
		end
	end

endmodule

// File: access_values.sv
// Reader peer; requests the account balance from the arbiter and holds the returned word
`timescale 1ns/10ps

module access_values #(
	parameter int ACCT_W = bank_pkg::ACCT_W
) (
	input  logic                clock,
	input  logic                rst_n,
	input  bank_pkg::step_t     step,
	input  bank_pkg::acct_t     acct,
	output logic                req,
	output bank_pkg::mem_req_t  mem,
	input  logic                gnt,
	input  logic                rvalid,
	input  bank_pkg::balance_t  rdata,
	output bank_pkg::balance_t  balance,
	output logic                rd_done
);
	import bank_pkg::*;

	logic issued;

	// Read data is captured on the same edge that ends the step
	assign rd_done = rvalid;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			req <= 1'b0;
			issued <= 1'b0;
		end
		else
		begin
			if (step != step_read)
				issued <= 1'b0;
			else if (!issued)
			begin
				req <= 1'b1;
				issued <= 1'b1;
			end
			if (gnt)
				req <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (step == step_read && !issued)
			mem <= '{we: 1'b0, addr: acct_t'(acct[ACCT_W-1:0]), wdata: '0};
		if (rvalid)
			balance <= rdata;
	end

endmodule

// File: store_values.sv
// Writer peer; requests a balance write from the arbiter and reports the grant as step done
`timescale 1ns/10ps

module store_values #(
	parameter int ACCT_W = bank_pkg::ACCT_W
) (
	input  logic               clock,
	input  logic               rst_n,
	input  bank_pkg::step_t    step,
	input  bank_pkg::acct_t    acct,
	input  bank_pkg::balance_t new_balance,
	output logic               req,
	output bank_pkg::mem_req_t mem,
	input  logic               gnt,
	output logic               wr_done
);
	import bank_pkg::*;

	logic issued;

	// Write lands in the RAM on the grant edge
	assign wr_done = gnt;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			req <= 1'b0;
			issued <= 1'b0;
		end
		else
		begin
			if (step != step_store)
				issued <= 1'b0;
			else if (!issued)
			begin
				req <= 1'b1;
				issued <= 1'b1;
			end
			if (gnt)
				req <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (step == step_store && !issued)
			mem <= '{we: 1'b1, addr: acct_t'(acct[ACCT_W-1:0]), wdata: new_balance};
	end

	// A waiting write keeps its request and payload until granted
	assert property (@(posedge clock) disable iff (!rst_n)
		req && !gnt |=> req && $stable(mem));

endmodule

// File: main.sv
// Ledger top level; ties controllers, datapath, RAM peers and arbiter together for the testbench
`timescale 1ns/10ps

module main #(
	parameter int ACCT_W = bank_pkg::ACCT_W
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               load,
	input  logic               start,
	input  bank_pkg::key_t     sw,
	input  logic               host_req,
	input  bank_pkg::mem_req_t host_mem,
	output logic               host_gnt,
	output bank_pkg::balance_t host_rdata,
	output logic               host_rvalid,
	output bank_pkg::result_t  result,
	output logic               done
);
	import bank_pkg::*;

	// Controller handshake
	logic     start_transaction;
	logic     finished;
	step_t    step;
	logic     dp_done;
	logic     rd_done;
	logic     wr_done;

	// Transaction operands
	key_t     key;
	amount_t  amount;
	acct_t    acct;
	balance_t balance;
	balance_t new_balance;

	// Peer side of the arbiter
	logic     rd_req;
	logic     wr_req;
	logic     rd_gnt;
	logic     wr_gnt;
	logic     rd_rvalid;
	mem_req_t rd_mem;
	mem_req_t wr_mem;

	main_control u_main_control (
		.clock             (clock),
		.rst_n             (rst_n),
		.load              (load),
		.start             (start),
		.sw                (sw),
		.finished          (finished),
		.start_transaction (start_transaction),
		.key               (key),
		.amount            (amount)
	);

	transaction_control u_transaction_control (
		.clock             (clock),
		.rst_n             (rst_n),
		.start_transaction (start_transaction),
		.dp_done           (dp_done),
		.rd_done           (rd_done),
		.wr_done           (wr_done),
		.step              (step),
		.finished          (finished)
	);

	datapath #(
		.ACCT_W (ACCT_W)
	) u_datapath (
		.clock       (clock),
		.rst_n       (rst_n),
		.step        (step),
		.key         (key),
		.amount      (amount),
		.balance_in  (balance),
		.acct        (acct),
		.new_balance (new_balance),
		.result      (result),
		.done_step   (dp_done),
		.done        (done)
	);

	access_values #(
		.ACCT_W (ACCT_W)
	) u_access_values (
		.clock   (clock),
		.rst_n   (rst_n),
		.step    (step),
		.acct    (acct),
		.req     (rd_req),
		.mem     (rd_mem),
		.gnt     (rd_gnt),
		.rvalid  (rd_rvalid),
		.rdata   (host_rdata),
		.balance (balance),
		.rd_done (rd_done)
	);

	store_values #(
		.ACCT_W (ACCT_W)
	) u_store_values (
		.clock       (clock),
		.rst_n       (rst_n),
		.step        (step),
		.acct        (acct),
		.new_balance (new_balance),
		.req         (wr_req),
		.mem         (wr_mem),
		.gnt         (wr_gnt),
		.wr_done     (wr_done)
	);

	// Read data bus is shared, rvalid tells each requester when it is theirs
	ram_arbiter #(
		.ACCT_W (ACCT_W)
	) u_ram_arbiter (
		.clock       (clock),
		.rst_n       (rst_n),
		.rd_req      (rd_req),
		.wr_req      (wr_req),
		.host_req    (host_req),
		.rd_mem      (rd_mem),
		.wr_mem      (wr_mem),
		.host_mem    (host_mem),
		.rd_gnt      (rd_gnt),
		.wr_gnt      (wr_gnt),
		.host_gnt    (host_gnt),
		.rd_rvalid   (rd_rvalid),
		.host_rvalid (host_rvalid),
		.rdata       (host_rdata)
	);

endmodule

// File: tb_main.sv
// Ledger testbench; preloads the RAM over the host port, runs withdrawals and checks them
`timescale 1ns/10ps

module tb_main;
	import bank_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int N_ACCT = 1 << ACCT_W;
	localparam int N_RANDOM = 30;
	localparam int OP_CYCLES = 40;
	localparam int SETTLE_CYCLES = 6;
	localparam int WINDOW_CYCLES = 30;
	// Host accesses, transactions and idle windows over all six tests
	localparam int N_OPS = (3 * N_ACCT + 8) + (N_RANDOM + 4) + 3;
	localparam int CYCLE_LIMIT = OP_CYCLES * N_OPS;

	logic        clock;
	logic        rst_n;
	logic        load;
	logic        start;
	key_t        sw;
	logic        host_req;
	mem_req_t    host_mem;
	logic        host_gnt;
	balance_t    host_rdata;
	logic        host_rvalid;
	result_t     result;
	logic        done;

	balance_t    model [N_ACCT];
	result_t     expected_q [$];
	logic [31:0] rng_state;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycle_count = 0;

	main #(
		.ACCT_W (ACCT_W)
	) u_main (
		.clock       (clock),
		.rst_n       (rst_n),
		.load        (load),
		.start       (start),
		.sw          (sw),
		.host_req    (host_req),
		.host_mem    (host_mem),
		.host_gnt    (host_gnt),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid),
		.result      (result),
		.done        (done)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	initial
	begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Account is the XOR of the key nibbles, modulo the account count
	function automatic acct_t hash_key(key_t k);
		return acct_t'((k[7:4] ^ k[3:0]) % N_ACCT);
	endfunction

	function automatic result_t reference(key_t k, amount_t amt);
		result_t  r;
		balance_t bal;
		r.acct = hash_key(k);
		bal = model[r.acct];
		r.approved = balance_t'(amt) <= bal;
		r.balance = r.approved ? bal - balance_t'(amt) : bal;
		return r;
	endfunction

	task automatic check_result(result_t exp);
		if (result.approved !== exp.approved)
		begin
			$display("[ERROR] %0t result.approved: expected %b, got %b",
				$time, exp.approved, result.approved);
			errors++;
		end
		if (result.acct !== exp.acct)
		begin
			$display("[ERROR] %0t result.acct: expected %0d, got %0d", $time, exp.acct, result.acct);
			errors++;
		end
		if (result.balance !== exp.balance)
		begin
			$display("[ERROR] %0t result.balance: expected %h, got %h",
				$time, exp.balance, result.balance);
			errors++;
		end
		// Model only moves on an approved withdrawal
		if (exp.approved)
			model[exp.acct] = exp.balance;
	endtask

	// Result check on every done pulse
	always @(negedge clock)
	begin
		if (rst_n && done)
		begin
			if (expected_q.size() == 0)
			begin
				$display("%0t: done pulsed with no transaction launched", $time);
				errors++;
			end
			else
				check_result(expected_q.pop_front());
		end
	end

	// Holds the request until a grant is seen just before a rising edge
	task automatic host_access(mem_req_t access, output logic granted);
		int waited;
		granted = 1'b0;
		waited = 0;
		@(negedge clock);
		host_req = 1'b1;
		host_mem = access;
		while (!granted && waited < OP_CYCLES)
		begin
			#(CLK_PERIOD / 4);
			granted = host_gnt;
			@(negedge clock);
			waited++;
		end
		host_req = 1'b0;
		if (!granted)
		begin
			$display("%0t: host access to account %0d was never granted", $time, access.addr);
			errors++;
		end
	endtask

	task automatic host_write(acct_t addr, balance_t data);
		logic granted;
		host_access('{we: 1'b1, addr: addr, wdata: data}, granted);
		if (granted)
			model[addr] = data;
	endtask

	task automatic host_read(acct_t addr);
		logic granted;
		int   waited;
		waited = 0;
		host_access('{we: 1'b0, addr: addr, wdata: '0}, granted);
		while (granted && !host_rvalid && waited < OP_CYCLES)
		begin
			@(negedge clock);
			waited++;
		end
		if (granted && !host_rvalid)
		begin
			$display("%0t: host read of account %0d returned no data", $time, addr);
			errors++;
		end
		else if (granted && host_rdata !== model[addr])
		begin
			$display("[ERROR] %0t host_rdata (account %0d): expected %h, got %h",
				$time, addr, model[addr], host_rdata);
			errors++;
		end
	endtask

	task automatic strobe_load(key_t value);
		@(negedge clock);
		load = 1'b1;
		sw = value;
		@(negedge clock);
		load = 1'b0;
	endtask

	task automatic strobe_start();
		@(negedge clock);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
	endtask

	// Store step and the return to idle follow done by a few cycles
	task automatic wait_done();
		int waited;
		waited = 0;
		while (!done && waited < OP_CYCLES)
		begin
			@(negedge clock);
			waited++;
		end
		if (!done)
		begin
			$display("%0t: transaction gave no done within %0d cycles", $time, OP_CYCLES);
			errors++;
			expected_q.delete();
		end
		repeat (SETTLE_CYCLES) @(negedge clock);
	endtask

	task automatic do_transaction(key_t k, amount_t amt);
		strobe_load(k);
		strobe_load(key_t'(amt));
		expected_q.push_back(reference(k, amt));
		strobe_start();
		wait_done();
	endtask

	task automatic expect_no_done(int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			if (done)
			begin
				$display("%0t: done pulsed after an ignored start strobe", $time);
				errors++;
			end
		end
	endtask

	task automatic report_test(string name, int errors_at_start);
		tests_run++;
		if (errors == errors_at_start)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d error(s)", tests_run, name, errors - errors_at_start);
		end
	endtask

	initial
	begin
		int      mark;
		key_t    k;
		key_t    prev_key;
		amount_t amt;
		acct_t   a;

		clock = 1'b0;
		rst_n = 1'b0;
		load = 1'b0;
		start = 1'b0;
		sw = '0;
		host_req = 1'b0;
		host_mem = '0;
		rng_state = 32'hf405718c;
		repeat (10) @(negedge clock);
		rst_n = 1'b1;

		mark = errors;
		@(negedge clock);
		if (done !== 1'b0)
		begin
			$display("[ERROR] %0t done: expected 0, got %b", $time, done);
			errors++;
		end
		if (host_gnt !== 1'b0)
		begin
			$display("[ERROR] %0t host_gnt: expected 0, got %b", $time, host_gnt);
			errors++;
		end
		if (result !== '0)
		begin
			$display("[ERROR] %0t result: expected %h, got %h", $time, result_t'('0), result);
			errors++;
		end
		// Balances up to 1023 give a mix of approvals and rejections
		for (int i = 0; i < N_ACCT; i++)
			host_write(acct_t'(i), balance_t'(next_random() & 32'h3ff));
		for (int i = 0; i < N_ACCT; i++)
			host_read(acct_t'(i));
		report_test("reset and preload", mark);

		mark = errors;
		k = 8'h3a;
		a = hash_key(k);
		host_write(a, 16'd1000);
		do_transaction(k, 8'd200);
		host_read(a);
		report_test("approved withdrawal", mark);

		mark = errors;
		k = 8'hc5;
		a = hash_key(k);
		host_write(a, 16'd50);
		do_transaction(k, 8'd120);
		host_read(a);
		report_test("rejected withdrawal", mark);

		mark = errors;
		prev_key = 8'h00;
		for (int i = 0; i < N_RANDOM; i++)
		begin
			// Complement of the last key hashes to the same account
			if (i % 3 == 2)
				k = ~prev_key;
			else
				k = key_t'(next_random());
			amt = amount_t'(next_random());
			do_transaction(k, amt);
			prev_key = k;
		end
		for (int i = 0; i < N_ACCT; i++)
			host_read(acct_t'(i));
		report_test("random transactions", mark);

		mark = errors;
		k = key_t'(next_random());
		amt = amount_t'(next_random());
		a = hash_key(k);
		fork
			do_transaction(k, amt);
			begin
				// Third read lands on the reader's request cycle and has to wait
				repeat (5) @(negedge clock);
				// Other accounts only, so the store order does not matter
				for (int j = 1; j <= 4; j++)
					host_read(acct_t'(a + j));
			end
		join
		report_test("host reads during a transaction", mark);

		mark = errors;
		strobe_start();
		expect_no_done(WINDOW_CYCLES);
		k = 8'h5e;
		amt = 8'h07;
		strobe_load(k);
		strobe_start();
		expect_no_done(10);
		strobe_load(key_t'(amt));
		expected_q.push_back(reference(k, amt));
		strobe_start();
		// Lands in busy and must be dropped
		strobe_start();
		wait_done();
		expect_no_done(WINDOW_CYCLES);
		report_test("ignored start strobes", mark);

		if (expected_q.size() != 0)
		begin
			$display("%0d transaction(s) never produced done", expected_q.size());
			errors++;
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
bank_pkg.sv
ram_unit.sv
ram_arbiter.sv
main_control.sv
transaction_control.sv
datapath.sv
access_values.sv
store_values.sv
main.sv
tb_main.sv

// File: Bender.yml
package:
  name: bank_ledger

sources:
  - bank_pkg.sv
  - ram_unit.sv
  - ram_arbiter.sv
  - main_control.sv
  - transaction_control.sv
  - datapath.sv
  - access_values.sv
  - store_values.sv
  - main.sv
  - target: test
    files:
      - tb_main.sv
